// File: Bender.yml
package:
  name: sd_init

sources:
  - common/sd_init_pkg.sv
  - common/spi_frame_if.sv
  - sd_spi/spi_frame_fsm.sv
  - sd_spi/response_capture.sv
  - src/init_sequencer.sv
  - src/response_bank.sv
  - src/sd_init_top.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/sd_card_model.sv
      - bench/tb_sd_init.sv

// File: bench/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  input  logic reset_req,
  output logic clock_100KHz,
  output logic Clear_n
);

  int hold = RESET_CYCLES;

  initial clock_100KHz = 1'b0;
  always #(PERIOD_NS / 2) clock_100KHz = !clock_100KHz;

  // Reset released on a falling edge
  always @(negedge clock_100KHz) begin
    if (reset_req) begin
      hold <= RESET_CYCLES - 1;
    end else if (hold > 0) begin
      hold <= hold - 1;
    end
  end

  assign Clear_n = (hold == 0) && !reset_req;

endmodule

`default_nettype wire

// File: bench/sd_card_model.sv
`timescale 1ns/1ns
`default_nettype none

module sd_card_model import sd_init_pkg::*; (
  input  logic clock_100KHz,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  // One entry per received frame: response, idle bytes before its start bit
  logic [39:0] resp_script [0:31];
  int          delay_script [0:31];
  int          script_len;
  int          script_pos;

  cmd_frame_t  frame_log [0:63];
  int          log_count;

  cmd_frame_t  frame;
  logic [39:0] resp;
  int          delay;
  int          bit_idx;

  ////////////////////////////////////////////////////////////
  // Frame receive and scripted answer
  ////////////////////////////////////////////////////////////
  initial begin
    miso = 1'b1;
    forever begin
      @(posedge clock_100KHz);
      // Start bit 0 with cs low opens a frame
      if (!cs && !mosi) begin
        frame = '0;
        repeat (CMD_BITS - 1) begin
          @(posedge clock_100KHz);
          frame = {frame[46:0], mosi};
        end
        // Transmission bit must be 1
        if (frame[46]) begin
          frame_log[log_count] = frame;
          log_count = log_count + 1;
          if (script_pos < script_len) begin
            resp  = resp_script[script_pos];
            delay = delay_script[script_pos];
          end else begin
            // Past the script, illegal command
            resp  = 40'h04_FFFF_FFFF;
            delay = 0;
          end
          script_pos = script_pos + 1;
          repeat (delay * 8) @(negedge clock_100KHz);
          for (bit_idx = RESP_BITS - 1; bit_idx >= 0; bit_idx--) begin
            @(negedge clock_100KHz);
            miso <= resp[bit_idx];
          end
          @(negedge clock_100KHz);
          miso <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_sd_init.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sd_init import sd_init_pkg::*; ();

  localparam logic [39:0] IDLE_RESP  = {R1_IDLE, 32'hFFFF_FFFF};
  localparam logic [39:0] READY_RESP = {R1_READY, 32'hFFFF_FFFF};
  // CCS bit clear
  localparam logic [39:0] BAD_OCR    = 40'h00_80FF_8000;

  logic        clock_100KHz;
  logic        Clear_n;
  logic        reset_req;
  logic        miso;
  logic [2:0]  resp_sel;
  logic        resp_msb;
  logic        cs;
  logic        mosi;
  logic        init_pass;
  logic [4:0]  pass_flags;
  logic [31:0] response_out;

  string       test_name;
  logic [39:0] resp_list [0:31];
  int          delay_list [0:31];
  int          n_resp;
  cmd_id_t     exp_cmds [0:31];
  int          exp_count;
  logic [5:0]  exp_flags;
  int          budget;
  int          cycle_count;
  int          busy;
  int          sel;
  int          msb;
  int          k;

  clock_gen clk_gen (
    .reset_req    (reset_req),
    .clock_100KHz (clock_100KHz),
    .Clear_n      (Clear_n)
  );

  sd_card_model card (
    .clock_100KHz (clock_100KHz),
    .cs           (cs),
    .mosi         (mosi),
    .miso         (miso)
  );

  sd_init_top sd_init_top_i (
    .clock_100KHz (clock_100KHz),
    .Clear_n      (Clear_n),
    .miso         (miso),
    .resp_sel     (resp_sel),
    .resp_msb     (resp_msb),
    .cs           (cs),
    .mosi         (mosi),
    .init_pass    (init_pass),
    .cmd0_pass    (pass_flags[0]),
    .cmd8_pass    (pass_flags[1]),
    .cmd55_pass   (pass_flags[2]),
    .acmd41_pass  (pass_flags[3]),
    .cmd58_pass   (pass_flags[4]),
    .response_out (response_out)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  always @(posedge clock_100KHz) begin
    cycle_count = cycle_count + 1;
    if (cycle_count * 10 > budget * 11) begin
      abort_run($sformatf("Timeout in %s: DUT gave no result after %0d clock cycles",
                          test_name, cycle_count));
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_frame(input string what, input cmd_frame_t expected,
                             input cmd_frame_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: %s expected %h actual %h", test_name, what, expected, actual));
    end
  endtask

  task automatic check_resp(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: %s expected %h actual %h", test_name, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: %s expected %b actual %b", test_name, what, expected, actual));
    end
  endtask

  task automatic check_resp_word(input string what, input sd_resp_u expected,
                                 input sd_resp_u actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: %s expected %h actual %h", test_name, what,
                          expected.raw, actual.raw));
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (actual != expected) begin
      abort_run($sformatf("Fail %s: %s expected %0d actual %0d", test_name, what,
                          expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  // Walks the scripted responses through the advance and retry rules.
  // Bits 4..0 are the pass flags in cmd_id_t order, bit 5 is init_pass
  function automatic logic [5:0] expected_outcome(input int n);
    cmd_id_t    cur;
    sd_resp_u   r;
    logic       ok;
    logic [5:0] flags;
    int         i;
    cur       = ID_CMD0;
    flags     = '0;
    exp_count = 0;
    for (i = 0; i < n && !flags[5]; i++) begin
      r.raw = resp_list[i];
      exp_cmds[exp_count] = cur;
      exp_count++;
      case (cur)
        ID_CMD0, ID_CMD55: ok = (r.f.r1 == R1_IDLE);
        ID_ACMD41:         ok = (r.f.r1 == R1_READY);
        ID_CMD8:           ok = (r.raw == CMD8_EXPECT);
        default:           ok = (r.raw == CMD58_EXPECT);
      endcase
      flags[cur] = ok;
      case (cur)
        ID_CMD0:   cur = ok ? ID_CMD8 : ID_CMD0;
        ID_CMD8:   cur = ok ? ID_CMD55 : ID_CMD8;
        ID_CMD55:  cur = ok ? ID_ACMD41 : ID_CMD55;
        ID_ACMD41: cur = ok ? ID_CMD58 : ID_CMD55;
        default:   flags[5] = ok;
      endcase
    end
    return flags;
  endfunction

  function automatic cmd_frame_t frame_of(input cmd_id_t id);
    case (id)
      ID_CMD0:   return CMD0_FRAME;
      ID_CMD8:   return CMD8_FRAME;
      ID_CMD55:  return CMD55_FRAME;
      ID_ACMD41: return ACMD41_FRAME;
      default:   return CMD58_FRAME;
    endcase
  endfunction

  // Selector code is the command id plus one
  function automatic sd_resp_u last_response(input int code);
    sd_resp_u last;
    int       i;
    last = '0;
    for (i = 0; i < exp_count; i++) begin
      if (int'(exp_cmds[i]) + 1 == code) begin
        last.raw = resp_list[i];
      end
    end
    return last;
  endfunction

  function automatic logic [31:0] expected_readback(input int code, input logic upper);
    sd_resp_u last;
    last = last_response(code);
    if ((code == SEL_CMD8 || code == SEL_CMD58) && !upper) begin
      return last.f.payload;
    end
    return {24'd0, last.f.r1};
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic add_response(input logic [39:0] resp, input int idle_bytes);
    resp_list[n_resp]  = resp;
    delay_list[n_resp] = idle_bytes;
    n_resp++;
  endtask

  // CMD0 and CMD8 answered correctly
  task automatic add_front(input int max_delay);
    add_response(IDLE_RESP, $urandom_range(max_delay, 0));
    add_response(CMD8_EXPECT, $urandom_range(max_delay, 0));
  endtask

  // CMD55 then ACMD41 with the card ready
  task automatic add_back(input int max_delay);
    add_response(IDLE_RESP, $urandom_range(max_delay, 0));
    add_response(READY_RESP, $urandom_range(max_delay, 0));
  endtask

  task automatic apply_reset();
    @(negedge clock_100KHz);
    reset_req <= 1'b1;
    @(negedge clock_100KHz);
    reset_req <= 1'b0;
    wait (Clear_n);
  endtask

  task automatic start_init(input string name);
    int held;
    int i;
    test_name = name;
    exp_flags = expected_outcome(n_resp);
    for (i = 0; i < n_resp; i++) begin
      card.resp_script[i]  = resp_list[i];
      card.delay_script[i] = delay_list[i];
      budget = budget + 120 + delay_list[i] * 8;
    end
    budget = budget + POWER_UP_CYCLES + 240;
    card.script_len = n_resp;
    card.script_pos = 0;
    card.log_count  = 0;
    apply_reset();
    held = 0;
    while (cs) begin
      @(posedge clock_100KHz);
      if (!mosi) begin
        abort_run($sformatf("In %s mosi went low during the power-up hold", test_name));
      end
      held++;
    end
    check_flag("power-up hold long enough", 1'b1, held >= POWER_UP_CYCLES);
  endtask

  task automatic finish_init();
    int i;
    if (exp_flags[5]) begin
      wait (init_pass);
    end else begin
      // Next frame means the last scripted result is in
      wait (card.log_count > exp_count);
    end
    @(negedge clock_100KHz);
    check_count("frames logged", exp_flags[5] ? exp_count : exp_count + 1, card.log_count);
    for (i = 0; i < exp_count; i++) begin
      check_frame($sformatf("frame %0d", i), frame_of(exp_cmds[i]), card.frame_log[i]);
    end
    for (i = 0; i < 5; i++) begin
      check_flag($sformatf("pass flag %0d", i), exp_flags[i], pass_flags[i]);
    end
    check_flag("init_pass", exp_flags[5], init_pass);
  endtask

  task automatic check_full_word(input resp_sel_t code);
    sd_resp_u word;
    @(negedge clock_100KHz);
    resp_sel <= code;
    resp_msb <= 1'b1;
    @(negedge clock_100KHz);
    word.f.r1 = response_out[7:0];
    resp_msb <= 1'b0;
    @(negedge clock_100KHz);
    word.f.payload = response_out;
    check_resp_word($sformatf("word on sel %0d", code), last_response(code), word);
  endtask

  initial begin
    void'($urandom(40));
    reset_req   = 1'b0;
    resp_sel    = 3'd0;
    resp_msb    = 1'b0;
    budget      = 0;
    cycle_count = 0;
    n_resp      = 0;

    n_resp = 0;
    add_front(0);
    add_back(0);
    add_response(CMD58_EXPECT, 0);
    start_init("clean card");
    finish_init();

    // ACMD41 busy a few times, each costing a CMD55 and ACMD41 pair
    n_resp = 0;
    add_front(0);
    busy = $urandom_range(4, 1);
    for (k = 0; k < busy; k++) begin
      add_response(IDLE_RESP, 0);
      add_response(IDLE_RESP, 0);
    end
    add_back(0);
    add_response(CMD58_EXPECT, 0);
    start_init("acmd41 busy");
    finish_init();
    check_count("frames with busy pairs", 5 + 2 * busy, card.log_count);

    n_resp = 0;
    add_response({8'h05, 32'hFFFF_FFFF}, 0);
    add_front(0);
    add_back(0);
    add_response(CMD58_EXPECT, 0);
    start_init("cmd0 retry");
    wait (card.log_count == 2);
    @(negedge clock_100KHz);
    check_flag("cmd0_pass after first attempt", 1'b0, pass_flags[0]);
    finish_init();

    n_resp = 0;
    add_front(6);
    add_back(6);
    add_response(CMD58_EXPECT, $urandom_range(6, 0));
    start_init("response delay");
    finish_init();

    n_resp = 0;
    add_front(2);
    add_back(2);
    add_response(CMD58_EXPECT, 0);
    start_init("readback");
    finish_init();
    for (sel = 0; sel < 8; sel++) begin
      for (msb = 0; msb < 2; msb++) begin
        @(negedge clock_100KHz);
        resp_sel <= sel[2:0];
        resp_msb <= msb[0];
        @(negedge clock_100KHz);
        check_resp($sformatf("sel %0d msb %0d", sel, msb), expected_readback(sel, msb[0]),
                   response_out);
      end
    end
    check_full_word(SEL_CMD8);
    check_full_word(SEL_CMD58);

    n_resp = 0;
    add_front(0);
    add_back(0);
    repeat (3) add_response(BAD_OCR, 0);
    start_init("bad ocr");
    finish_init();

    test_name = "reset";
    apply_reset();
    check_flag("cs", 1'b1, cs);
    check_flag("mosi", 1'b1, mosi);
    check_flag("init_pass", 1'b0, init_pass);
    for (k = 0; k < 5; k++) begin
      check_flag($sformatf("pass flag %0d", k), 1'b0, pass_flags[k]);
    end
    check_resp("response_out", 32'd0, response_out);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: common/sd_init_pkg.sv
`default_nettype none

package sd_init_pkg;

  ////////////////////////////////////////////////////////////
  // Command frames, CRC included
  ////////////////////////////////////////////////////////////
  typedef logic [47:0] cmd_frame_t;

  localparam cmd_frame_t CMD0_FRAME   = 48'h40_0000_0000_95;
  localparam cmd_frame_t CMD8_FRAME   = 48'h48_0000_01AA_87;
  localparam cmd_frame_t CMD55_FRAME  = 48'h77_0000_0000_65;
  // HCS bit set
  localparam cmd_frame_t ACMD41_FRAME = 48'h69_4000_0000_77;
  localparam cmd_frame_t CMD58_FRAME  = 48'h7A_0000_0000_FD;

  // R1 byte first, then 32 bits of R3/R7 payload
  typedef struct packed {
    logic [7:0]  r1;
    logic [31:0] payload;
  } sd_resp_s;

  typedef union packed {
    logic [39:0] raw;
    sd_resp_s    f;
  } sd_resp_u;

  localparam logic [7:0]  R1_IDLE      = 8'h01;
  localparam logic [7:0]  R1_READY     = 8'h00;
  localparam logic [39:0] CMD8_EXPECT  = 40'h01_0000_01AA;
  localparam logic [39:0] CMD58_EXPECT = 40'h00_C0FF_8000;

  // Frame timing, in cycles of clock_100KHz
  localparam logic [14:0] POWER_UP_CYCLES = 15'd25064;
  localparam int IDLE_CLOCKS = 8;
  localparam int CMD_BITS    = 48;
  localparam int RESP_BITS   = 40;

  typedef enum logic [2:0] {
    SEL_NONE   = 3'd0,
    SEL_CMD0   = 3'd1,
    SEL_CMD8   = 3'd2,
    SEL_CMD55  = 3'd3,
    SEL_ACMD41 = 3'd4,
    SEL_CMD58  = 3'd5
  } resp_sel_t;

  typedef enum logic [2:0] {
    ID_CMD0,
    ID_CMD8,
    ID_CMD55,
    ID_ACMD41,
    ID_CMD58
  } cmd_id_t;

endpackage

`default_nettype wire

// File: common/spi_frame_if.sv
`timescale 1ns/1ns
`default_nettype none

interface spi_frame_if import sd_init_pkg::*; ();

  cmd_frame_t cmd_word;
  logic       capture_en;
  sd_resp_u   resp_word;
  logic       result_strobe;
  logic       init_done;

  modport fsm (output capture_en, output result_strobe, input cmd_word, input init_done);

  modport capture (input capture_en, output resp_word);

  modport sequencer (input resp_word, input result_strobe, output cmd_word, output init_done);

endinterface

`default_nettype wire

// File: project.f
common/sd_init_pkg.sv
common/spi_frame_if.sv
sd_spi/spi_frame_fsm.sv
sd_spi/response_capture.sv
src/init_sequencer.sv
src/response_bank.sv
src/sd_init_top.sv
bench/clock_gen.sv
bench/sd_card_model.sv
bench/tb_sd_init.sv

// File: sd_spi/response_capture.sv
`timescale 1ns/1ns
`default_nettype none

module response_capture import sd_init_pkg::*; (
  input  logic          clock_100KHz,
  input  logic          Clear_n,
  input  logic          miso,
  spi_frame_if.capture  bus
);

  logic [RESP_BITS-1:0] shift_reg;

  // Card drives on falling edge, sample on rising
  always_ff @(posedge clock_100KHz or negedge Clear_n) begin
    if (!Clear_n) begin
      shift_reg <= '0;
    end else if (bus.capture_en) begin
      shift_reg <= {shift_reg[RESP_BITS-2:0], miso};
    end
  end

  assign bus.resp_word = shift_reg;

endmodule

`default_nettype wire

// File: sd_spi/spi_frame_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module spi_frame_fsm import sd_init_pkg::*; (
  input  logic            clock_100KHz,
  input  logic            Clear_n,
  input  logic            miso,
  spi_frame_if.fsm        bus,
  output logic            cs,
  output logic            mosi,
  output logic            init_pass
);

  typedef enum logic [2:0] {
    ST_RESET,
    ST_POWER_UP,
    ST_LEAD_IDLE,
    ST_COMMAND,
    ST_WAIT,
    ST_RESPONSE,
    ST_TRAIL_IDLE,
    ST_FINISH
  } phase_t;

  phase_t      state;
  logic [14:0] pwr_cnt;
  logic [5:0]  bit_cnt;
  logic        bit_last;

  // Last clock of each counted phase
  always_comb begin
    case (state)
      ST_LEAD_IDLE, ST_TRAIL_IDLE: bit_last = (bit_cnt == 6'(IDLE_CLOCKS - 1));
      ST_COMMAND:                  bit_last = (bit_cnt == 6'(CMD_BITS - 1));
      // Start bit is seen in the wait phase
      ST_RESPONSE:                 bit_last = (bit_cnt == 6'(RESP_BITS - 2));
      default:                     bit_last = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Phase machine, falling edge
  ////////////////////////////////////////////////////////////
  always_ff @(negedge clock_100KHz or negedge Clear_n) begin
    if (!Clear_n) begin
      state   <= ST_RESET;
      pwr_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_RESET: begin
          pwr_cnt <= '0;
          state   <= ST_POWER_UP;
        end
        ST_POWER_UP: begin
          if (pwr_cnt == POWER_UP_CYCLES - 15'd1) begin
            state <= ST_LEAD_IDLE;
          end else begin
            pwr_cnt <= pwr_cnt + 15'd1;
          end
        end
        ST_LEAD_IDLE: begin
          if (bit_last) begin
            state <= ST_COMMAND;
          end
        end
        ST_COMMAND: begin
          if (bit_last) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (!miso) begin
            state <= ST_RESPONSE;
          end
        end
        ST_RESPONSE: begin
          if (bit_last) begin
            state <= ST_TRAIL_IDLE;
          end
        end
        ST_TRAIL_IDLE: begin
          if (bit_last) begin
            state <= bus.init_done ? ST_FINISH : ST_LEAD_IDLE;
          end
        end
        ST_FINISH: state <= ST_FINISH;
        default:   state <= ST_RESET;
      endcase

      if (state inside {ST_LEAD_IDLE, ST_COMMAND, ST_RESPONSE, ST_TRAIL_IDLE}) begin
        bit_cnt <= bit_last ? 6'd0 : bit_cnt + 6'd1;
      end else begin
        bit_cnt <= '0;
      end
    end
  end

  assign cs   = !(state inside {ST_LEAD_IDLE, ST_COMMAND, ST_WAIT, ST_RESPONSE});
  // MSB first
  assign mosi = (state == ST_COMMAND) ? bus.cmd_word[CMD_BITS - 1 - bit_cnt] : 1'b1;

  assign bus.capture_en    = state inside {ST_WAIT, ST_RESPONSE};
  // Second trailing idle clock
  assign bus.result_strobe = (state == ST_TRAIL_IDLE) && (bit_cnt == 6'd1);
  assign init_pass         = (state == ST_FINISH);

endmodule

`default_nettype wire

// File: src/init_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module init_sequencer import sd_init_pkg::*; (
  input  logic           clock_100KHz,
  input  logic           Clear_n,
  spi_frame_if.sequencer bus,
  output logic           cmd0_pass,
  output logic           cmd8_pass,
  output logic           cmd55_pass,
  output logic           acmd41_pass,
  output logic           cmd58_pass,
  output logic           store,
  output cmd_id_t        store_id,
  output sd_resp_u       store_resp
);

  cmd_id_t cur_cmd;
  logic    r1_idle;
  logic    r1_ready;
  logic    if_cond_ok;
  logic    ocr_ok;

  assign r1_idle    = (bus.resp_word.f.r1 == R1_IDLE);
  assign r1_ready   = (bus.resp_word.f.r1 == R1_READY);
  assign if_cond_ok = (bus.resp_word.raw == CMD8_EXPECT);
  assign ocr_ok     = (bus.resp_word.raw == CMD58_EXPECT);

  always_comb begin
    case (cur_cmd)
      ID_CMD8:   bus.cmd_word = CMD8_FRAME;
      ID_CMD55:  bus.cmd_word = CMD55_FRAME;
      ID_ACMD41: bus.cmd_word = ACMD41_FRAME;
      ID_CMD58:  bus.cmd_word = CMD58_FRAME;
      default:   bus.cmd_word = CMD0_FRAME;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Advance or retry on each result
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock_100KHz or negedge Clear_n) begin
    if (!Clear_n) begin
      cur_cmd       <= ID_CMD0;
      cmd0_pass     <= 1'b0;
      cmd8_pass     <= 1'b0;
      cmd55_pass    <= 1'b0;
      acmd41_pass   <= 1'b0;
      cmd58_pass    <= 1'b0;
      bus.init_done <= 1'b0;
    end else if (bus.result_strobe) begin
      case (cur_cmd)
        ID_CMD0: begin
          cmd0_pass <= r1_idle;
          cur_cmd   <= r1_idle ? ID_CMD8 : ID_CMD0;
        end
        ID_CMD8: begin
          cmd8_pass <= if_cond_ok;
          cur_cmd   <= if_cond_ok ? ID_CMD55 : ID_CMD8;
        end
        ID_CMD55: begin
          cmd55_pass <= r1_idle;
          cur_cmd    <= r1_idle ? ID_ACMD41 : ID_CMD55;
        end
        ID_ACMD41: begin
          acmd41_pass <= r1_ready;
          // Card still busy, go back through CMD55
          cur_cmd     <= r1_ready ? ID_CMD58 : ID_CMD55;
        end
        ID_CMD58: begin
          cmd58_pass <= ocr_ok;
          if (ocr_ok) begin
            bus.init_done <= 1'b1;
          end
        end
        default: cur_cmd <= ID_CMD0;
      endcase
    end
  end

  // Bank write happens on the same edge, before cur_cmd moves
  assign store      = bus.result_strobe;
  assign store_id   = cur_cmd;
  assign store_resp = bus.resp_word;

endmodule

`default_nettype wire

// File: src/response_bank.sv
`timescale 1ns/1ns
`default_nettype none

module response_bank import sd_init_pkg::*; (
  input  logic        clock_100KHz,
  input  logic        Clear_n,
  input  logic        store,
  input  cmd_id_t     store_id,
  input  sd_resp_u    store_resp,
  input  logic [2:0]  resp_sel,
  input  logic        resp_msb,
  output logic [31:0] response_out
);

  logic [7:0] cmd0_r1;
  logic [7:0] cmd55_r1;
  logic [7:0] acmd41_r1;
  sd_resp_u   cmd8_word;
  sd_resp_u   cmd58_word;

  always_ff @(posedge clock_100KHz or negedge Clear_n) begin
    if (!Clear_n) begin
      cmd0_r1    <= '0;
      cmd55_r1   <= '0;
      acmd41_r1  <= '0;
      cmd8_word  <= '0;
      cmd58_word <= '0;
    end else if (store) begin
      case (store_id)
        ID_CMD0:   cmd0_r1    <= store_resp.f.r1;
        ID_CMD8:   cmd8_word  <= store_resp;
        ID_CMD55:  cmd55_r1   <= store_resp.f.r1;
        ID_ACMD41: acmd41_r1  <= store_resp.f.r1;
        ID_CMD58:  cmd58_word <= store_resp;
        default:   cmd0_r1    <= cmd0_r1;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Registered readback
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock_100KHz or negedge Clear_n) begin
    if (!Clear_n) begin
      response_out <= '0;
    end else begin
      case (resp_sel_t'(resp_sel))
        SEL_NONE:   response_out <= '0;
        SEL_CMD0:   response_out <= {24'd0, cmd0_r1};
        SEL_CMD8:   response_out <= resp_msb ? {24'd0, cmd8_word.f.r1} : cmd8_word.f.payload;
        SEL_CMD55:  response_out <= {24'd0, cmd55_r1};
        SEL_ACMD41: response_out <= {24'd0, acmd41_r1};
        SEL_CMD58:  response_out <= resp_msb ? {24'd0, cmd58_word.f.r1} : cmd58_word.f.payload;
        // Codes 6 and 7
        default:    response_out <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/sd_init_top.sv
`timescale 1ns/1ns
`default_nettype none

module sd_init_top import sd_init_pkg::*; (
  input  logic        clock_100KHz,
  input  logic        Clear_n,
  input  logic        miso,
  input  logic [2:0]  resp_sel,
  input  logic        resp_msb,
  output logic        cs,
  output logic        mosi,
  output logic        init_pass,
  output logic        cmd0_pass,
  output logic        cmd8_pass,
  output logic        cmd55_pass,
  output logic        acmd41_pass,
  output logic        cmd58_pass,
  output logic [31:0] response_out
);

  logic     store;
  cmd_id_t  store_id;
  sd_resp_u store_resp;

  spi_frame_if frame_bus ();

  spi_frame_fsm u_fsm (
    .clock_100KHz (clock_100KHz),
    .Clear_n      (Clear_n),
    .miso         (miso),
    .bus          (frame_bus.fsm),
    .cs           (cs),
    .mosi         (mosi),
    .init_pass    (init_pass)
  );

  response_capture u_capture (
    .clock_100KHz (clock_100KHz),
    .Clear_n      (Clear_n),
    .miso         (miso),
    .bus          (frame_bus.capture)
  );

  init_sequencer u_sequencer (
    .clock_100KHz (clock_100KHz),
    .Clear_n      (Clear_n),
    .bus          (frame_bus.sequencer),
    .cmd0_pass    (cmd0_pass),
    .cmd8_pass    (cmd8_pass),
    .cmd55_pass   (cmd55_pass),
    .acmd41_pass  (acmd41_pass),
    .cmd58_pass   (cmd58_pass),
    .store        (store),
    .store_id     (store_id),
    .store_resp   (store_resp)
  );

  response_bank u_bank (
    .clock_100KHz (clock_100KHz),
    .Clear_n      (Clear_n),
    .store        (store),
    .store_id     (store_id),
    .store_resp   (store_resp),
    .resp_sel     (resp_sel),
    .resp_msb     (resp_msb),
    .response_out (response_out)
  );

endmodule

`default_nettype wire
